// ==== design/gfx_pkg.sv ====
// frame is fixed at 640 x 480 row-major 16-bit words; coordinates are signed 12-bit (-2048..2047)
package gfx_pkg;

  // plain vector types with a meaning
  typedef logic signed [11:0] coord_t;    // screen x or y, may lie off-frame
  typedef logic        [15:0] color_t;    // rgb565
  typedef logic        [18:0] fb_addr_t;  // frame-buffer word address

  // visible frame, typed as coordinates so clip compares stay signed
  localparam coord_t FB_WIDTH  = 12'sd640;  // pixels per row
  localparam coord_t FB_HEIGHT = 12'sd480;  // rows per frame

  // kind of draw command
  typedef enum logic [1:0] {
    OP_POINT     = 2'd0,  // single pixel at a
    OP_LINE      = 2'd1,  // full line a to b
    OP_LINE_TO_Y = 2'd2   // line a to b, ends early on stop_y
  } draw_op_e;

  // one host command, held by the sequencer for its whole run
  typedef struct packed {
    draw_op_e op;      // command kind
    coord_t   ax;      // start x
    coord_t   ay;      // start y
    coord_t   bx;      // end x
    coord_t   by;      // end y
    coord_t   stop_y;  // stop scanline, OP_LINE_TO_Y only
    color_t   color;   // colour of every pixel of the command
  } draw_cmd_t;

  // one generated pixel position
  typedef struct packed {
    coord_t x;
    coord_t y;
  } pixel_t;

  // command sequencer states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,  // waiting for a command
    RUN    = 2'd1,  // generator running
    FINISH = 2'd2   // run dropped, done pulse next
  } seq_state_e;

endpackage

// ==== design/line_generator.sv ====
// a, b and the stop controls must stay stable while run is high; draw_busy freezes the pixel path
module line_generator
  import gfx_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   run,             // level, rising edge starts a command
  input  logic   draw_busy,       // writer stalled, hold everything on the pixel path
  input  logic   pass_thru_a,     // present a as a single pixel
  input  logic   ena_stop_y,      // end on the first pixel on stop_ypos
  input  pixel_t a,               // line start
  input  pixel_t b,               // line end
  input  coord_t stop_ypos,       // stop scanline
  output logic   busy,            // running a command
  output pixel_t pix,             // current pixel
  output logic   pixel_data_rdy,  // pix is valid
  output logic   ypos_stopped,    // ended on the stop scanline
  output logic   line_complete    // ended at b, or single pixel taken
);

  // 16 bits holds 2 * err for deltas up to 4095
  typedef logic signed [15:0] err_t;

  typedef enum logic {
    PH_SETUP = 1'b0,  // load error term
    PH_PLOT  = 1'b1   // step one pixel per cycle
  } phase_e;

  logic   last_run;   // run seen high and taken
  logic   start;      // run rising edge
  logic   same_pt;    // a equals b, treated as a point
  logic   draw_line;  // stepping a line
  logic   pass_pend;  // single pixel presented, waiting to be taken
  phase_e phase;
  coord_t xdir;       // +1 or -1
  coord_t ydir;
  err_t   dx;         // abs delta x
  err_t   dy;         // minus abs delta y
  err_t   errd;       // bresenham error term
  err_t   e2;         // doubled error
  err_t   err_nx;
  pixel_t pix_nx;     // next pixel on the path
  pixel_t b_l;        // latched end point
  logic   stop_en_l;
  coord_t stop_l;

  always_comb begin
    start   = run && !last_run;
    same_pt = (a == b);
    e2      = errd <<< 1;
    err_nx  = errd;
    pix_nx  = pix;
    if (e2 >= dy) begin  // x step
      err_nx   = err_nx + dy;
      pix_nx.x = pix.x + xdir;
    end
    if (e2 <= dx) begin  // y step, uses the same doubled error
      err_nx   = err_nx + dx;
      pix_nx.y = pix.y + ydir;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_run       <= 1'b0;
      draw_line      <= 1'b0;
      pass_pend      <= 1'b0;
      phase          <= PH_SETUP;
      busy           <= 1'b0;
      pixel_data_rdy <= 1'b0;
      ypos_stopped   <= 1'b0;
      line_complete  <= 1'b0;
      pix            <= '0;
      b_l            <= '0;
      stop_en_l      <= 1'b0;
      stop_l         <= '0;
      xdir           <= '0;
      ydir           <= '0;
      dx             <= '0;
      dy             <= '0;
      errd           <= '0;
    end else begin
      // status towards the sequencer follows run even while frozen,
      // so a long stall cannot leave a stale flag or a missed start
      if (!run) begin
        last_run      <= 1'b0;
        line_complete <= 1'b0;
        ypos_stopped  <= 1'b0;
      end
      if (!draw_busy) begin
        if (run) begin
          last_run <= 1'b1;  // start is consumed only when not frozen
        end
        if (start) begin
          busy          <= 1'b1;
          line_complete <= 1'b0;
          ypos_stopped  <= 1'b0;
          phase         <= PH_SETUP;
          pix           <= a;  // start pixel, shown after setup
          b_l           <= b;
          stop_en_l     <= ena_stop_y;
          stop_l        <= stop_ypos;
          xdir          <= (b.x < a.x) ? -12'sd1 : 12'sd1;
          ydir          <= (b.y < a.y) ? -12'sd1 : 12'sd1;
          dx            <= (b.x > a.x) ? err_t'(b.x) - err_t'(a.x)
                                       : err_t'(a.x) - err_t'(b.x);
          dy            <= (a.y > b.y) ? err_t'(b.y) - err_t'(a.y)  // negative abs dy
                                       : err_t'(a.y) - err_t'(b.y);
          if (pass_thru_a || same_pt) begin
            pixel_data_rdy <= 1'b1;  // a shown next cycle
            pass_pend      <= 1'b1;
            draw_line      <= 1'b0;
          end else begin
            pixel_data_rdy <= 1'b0;  // nothing valid during setup
            pass_pend      <= 1'b0;
            draw_line      <= 1'b1;
          end
        end else if (pass_pend) begin
          // writer took the single pixel at this edge
          pass_pend      <= 1'b0;
          pixel_data_rdy <= 1'b0;
          busy           <= 1'b0;
          line_complete  <= 1'b1;
        end else if (draw_line) begin
          case (phase)
            PH_SETUP: begin
              errd           <= dx + dy;
              phase          <= PH_PLOT;
              pixel_data_rdy <= 1'b1;  // start pixel valid from here
            end
            PH_PLOT: begin
              if (pix == b_l) begin  // end point was just taken
                line_complete  <= 1'b1;
                draw_line      <= 1'b0;
                pixel_data_rdy <= 1'b0;
                busy           <= 1'b0;
                phase          <= PH_SETUP;
              end else if (stop_en_l && pix.y == stop_l) begin  // first pixel on stop row
                ypos_stopped   <= 1'b1;
                draw_line      <= 1'b0;
                pixel_data_rdy <= 1'b0;
                busy           <= 1'b0;
                phase          <= PH_SETUP;
              end else begin
                errd <= err_nx;
                pix  <= pix_nx;
              end
            end
          endcase
        end else begin  // idle, drop the one-cycle flags
          pixel_data_rdy <= 1'b0;
          line_complete  <= 1'b0;
          ypos_stopped   <= 1'b0;
          busy           <= 1'b0;
          phase          <= PH_SETUP;
        end
      end
    end
  end

endmodule

// ==== design/geo_cmd_seq.sv ====
// one command at a time; strobes while cmd_busy is high are dropped, op code 3 is drawn as a line
module geo_cmd_seq
  import gfx_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      cmd_valid,      // one-cycle command strobe
  input  draw_cmd_t cmd,
  output logic      cmd_busy,       // command in progress
  output logic      cmd_done,       // one-cycle end pulse
  output logic      cmd_stopped,    // with cmd_done, ended on stop_y
  output logic      run,            // level to the generator
  output logic      pass_thru_a,
  output logic      ena_stop_y,
  output pixel_t    a,
  output pixel_t    b,
  output coord_t    stop_ypos,
  output color_t    color,          // held for the whole command
  input  logic      line_complete,
  input  logic      ypos_stopped
);

  seq_state_e state;
  draw_cmd_t  cmd_r;     // accepted command
  logic       accept;
  logic       hit_stop;  // ended on the stop scanline

  assign cmd_busy = (state != IDLE);
  assign accept   = cmd_valid && !cmd_busy;

  // command fields towards the generator and writer
  assign pass_thru_a = (cmd_r.op == OP_POINT);
  assign ena_stop_y  = (cmd_r.op == OP_LINE_TO_Y);
  assign a.x         = cmd_r.ax;
  assign a.y         = cmd_r.ay;
  assign b.x         = cmd_r.bx;
  assign b.y         = cmd_r.by;
  assign stop_ypos   = cmd_r.stop_y;
  assign color       = cmd_r.color;

  // payload, only loaded on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_r <= cmd;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= IDLE;
      run         <= 1'b0;
      hit_stop    <= 1'b0;
      cmd_done    <= 1'b0;
      cmd_stopped <= 1'b0;
    end else begin
      cmd_done    <= 1'b0;  // pulses by default low
      cmd_stopped <= 1'b0;
      case (state)
        IDLE: begin
          if (cmd_valid) begin  // busy is low here
            run      <= 1'b1;  // generator sees the rising edge next cycle
            hit_stop <= 1'b0;
            state    <= RUN;
          end
        end
        RUN: begin
          if (line_complete || ypos_stopped) begin
            run      <= 1'b0;
            hit_stop <= ypos_stopped && !line_complete;
            state    <= FINISH;
          end
        end
        FINISH: begin
          cmd_done    <= 1'b1;  // same cycle as busy going low
          cmd_stopped <= hit_stop;
          state       <= IDLE;
        end
        default: begin
          run   <= 1'b0;
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

// ==== design/pixel_writer.sv ====
// clips to 640 x 480 and writes one word per pixel; a stalled write holds address and colour
module pixel_writer
  import gfx_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  pixel_t   pix,             // pixel from the generator
  input  logic     pixel_data_rdy,  // pix valid
  input  color_t   color,           // command colour
  input  logic     mem_stall,       // frame buffer not ready
  output logic     draw_busy,       // freeze the generator
  output logic     wr_en,
  output fb_addr_t wr_addr,
  output color_t   wr_color
);

  logic     take;      // pixel accepted this cycle
  logic     in_frame;  // pixel lies on the visible frame
  fb_addr_t addr_nx;

  assign draw_busy = wr_en && mem_stall;  // write held, nothing new taken
  assign take      = pixel_data_rdy && !draw_busy;

  assign in_frame = (pix.x >= 12'sd0) && (pix.x < FB_WIDTH) &&
                    (pix.y >= 12'sd0) && (pix.y < FB_HEIGHT);

  // row-major, only meaningful when in_frame so the low bits are enough
  assign addr_nx = fb_addr_t'(pix.y[9:0]) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(pix.x[9:0]);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_en <= 1'b0;
    end else if (!draw_busy) begin
      wr_en <= take && in_frame;  // clipped pixels leave a gap
    end
  end

  // write payload
  always_ff @(posedge clk) begin
    if (take && in_frame) begin
      wr_addr  <= addr_nx;
      wr_color <= color;  // captured with the pixel, safe if the next command starts
    end
  end

endmodule

// ==== design/geo_draw_top.sv ====
// no handshake on the command side; cmd_done may come before a stalled last write has left
module geo_draw_top
  import gfx_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      cmd_valid,
  input  draw_cmd_t cmd,
  output logic      cmd_busy,
  output logic      cmd_done,
  output logic      cmd_stopped,
  output logic      wr_en,
  output fb_addr_t  wr_addr,
  output color_t    wr_color,
  input  logic      mem_stall
);

  logic   run;
  logic   pass_thru_a;
  logic   ena_stop_y;
  pixel_t a;
  pixel_t b;
  coord_t stop_ypos;
  color_t color;          // command colour to the writer
  logic   line_complete;
  logic   ypos_stopped;
  pixel_t pix;
  logic   pixel_data_rdy;
  logic   draw_busy;      // writer stall back to the generator

  geo_cmd_seq u_seq (
    .clk           (clk),
    .arst_n        (arst_n),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .cmd_busy      (cmd_busy),
    .cmd_done      (cmd_done),
    .cmd_stopped   (cmd_stopped),
    .run           (run),
    .pass_thru_a   (pass_thru_a),
    .ena_stop_y    (ena_stop_y),
    .a             (a),
    .b             (b),
    .stop_ypos     (stop_ypos),
    .color         (color),
    .line_complete (line_complete),
    .ypos_stopped  (ypos_stopped)
  );

  line_generator u_gen (
    .clk            (clk),
    .arst_n         (arst_n),
    .run            (run),
    .draw_busy      (draw_busy),
    .pass_thru_a    (pass_thru_a),
    .ena_stop_y     (ena_stop_y),
    .a              (a),
    .b              (b),
    .stop_ypos      (stop_ypos),
    .busy           (),          // sequencer tracks completion through the flags
    .pix            (pix),
    .pixel_data_rdy (pixel_data_rdy),
    .ypos_stopped   (ypos_stopped),
    .line_complete  (line_complete)
  );

  pixel_writer u_wr (
    .clk            (clk),
    .arst_n         (arst_n),
    .pix            (pix),
    .pixel_data_rdy (pixel_data_rdy),
    .color          (color),
    .mem_stall      (mem_stall),
    .draw_busy      (draw_busy),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_color       (wr_color)
  );

endmodule

// ==== dv/tb_line_model.sv ====
// reference model only; coordinates are handled as int, so lines up to 4095 pixels long are safe
package tb_line_model;
  import gfx_pkg::*;

  typedef logic [34:0] wr_word_t;  // {address, colour} of one frame-buffer write

  wr_word_t exp_q[$];  // writes still owed by the DUT, oldest first

  // clip rule, then row-major word address
  function automatic void push_pixel(input int x, input int y, input color_t col);
    if (x >= 0 && x < int'(FB_WIDTH) && y >= 0 && y < int'(FB_HEIGHT)) begin
      exp_q.push_back({fb_addr_t'(y * int'(FB_WIDTH) + x), col});
    end
  endfunction

  // queues the writes of one command, returns the expected cmd_stopped
  function automatic logic model_cmd(input draw_cmd_t c);
    int x;
    int y;
    int bx;
    int by;
    int xdir;
    int ydir;
    int dx;
    int dy;
    int err;
    int e2;
    int guard;
    x  = int'(c.ax);
    y  = int'(c.ay);
    bx = int'(c.bx);
    by = int'(c.by);
    if (c.op == OP_POINT || (x == bx && y == by)) begin  // single pixel path
      push_pixel(x, y, c.color);
      return 1'b0;
    end
    xdir = (bx < x) ? -1 : 1;
    ydir = (by < y) ? -1 : 1;
    dx   = (bx > x) ? bx - x : x - bx;
    dy   = (by > y) ? y - by : by - y;  // negative abs dy
    err  = dx + dy;
    for (guard = 0; guard < 8192; guard++) begin
      push_pixel(x, y, c.color);
      if (x == bx && y == by) return 1'b0;  // end point wins over stop row
      if (c.op == OP_LINE_TO_Y && y == int'(c.stop_y)) return 1'b1;
      e2 = 2 * err;
      if (e2 >= dy) begin
        err = err + dy;
        x   = x + xdir;
      end
      if (e2 <= dx) begin
        err = err + dx;
        y   = y + ydir;
      end
    end
    return 1'b0;
  endfunction

endpackage

// ==== dv/tb_geo_draw.sv ====
// random commands and memory stalls from a fixed seed; every write is checked against tb_line_model
module tb_geo_draw
  import gfx_pkg::*, tb_line_model::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic      clk;
  logic      arst_n;
  logic      cmd_valid;
  draw_cmd_t cmd;
  logic      cmd_busy;
  logic      cmd_done;
  logic      cmd_stopped;
  logic      wr_en;
  fb_addr_t  wr_addr;
  color_t    wr_color;
  logic      mem_stall;

  integer    seed;
  int        errors;
  int        tests_pass;
  int        tests_fail;
  logic      stall_on;    // random stall generator enabled
  logic      stall_nx;    // stall drawn at the rising edge, driven at the falling edge
  logic      held;        // write was stalled at the last edge
  fb_addr_t  held_addr;
  color_t    held_color;

  geo_draw_top UUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .cmd_busy    (cmd_busy),
    .cmd_done    (cmd_done),
    .cmd_stopped (cmd_stopped),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_color    (wr_color),
    .mem_stall   (mem_stall)
  );

  always #2 clk = ~clk;  // 4 ns period

  task automatic check_val(input string msg, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, msg, got, exp);
      errors++;
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // write monitor, samples before the DUT's registers move
  always @(posedge clk) begin
    wr_word_t w;
    if (arst_n) begin
      if (held) begin  // stalled write must stay put
        check_val("wr_en held", 64'(wr_en), 64'd1);
        check_val("held address", 64'(wr_addr), 64'(held_addr));
        check_val("held colour", 64'(wr_color), 64'(held_color));
      end
      held       = wr_en && mem_stall;
      held_addr  = wr_addr;
      held_color = wr_color;
      if (wr_en && !mem_stall) begin
        if (exp_q.size() == 0) begin
          $display("at %0t the DUT wrote address %0h that the model did not expect", $time, wr_addr);
          errors++;
        end else begin
          w = exp_q.pop_front();
          check_val("write address", 64'(wr_addr), 64'(w[34:16]));
          check_val("write colour", 64'(wr_color), 64'(w[15:0]));
        end
      end
    end
  end

  // stall value is drawn away from the falling edge where commands are made
  always @(posedge clk) begin
    stall_nx = stall_on && (($unsigned($random(seed)) % 10) < 3);
  end

  // stalls change on the falling edge like every other input
  always @(negedge clk) begin
    mem_stall <= stall_nx;
  end

  function automatic draw_cmd_t make_cmd(input draw_op_e op, input int ax, input int ay,
                                         input int bx, input int by, input int sy);
    draw_cmd_t c;
    c.op     = op;
    c.ax     = coord_t'(ax);
    c.ay     = coord_t'(ay);
    c.bx     = coord_t'(bx);
    c.by     = coord_t'(by);
    c.stop_y = coord_t'(sy);
    c.color  = color_t'($random(seed));
    return c;
  endfunction

  // model, issue, wait for done and for the last write, then check
  task automatic run_cmd(input draw_cmd_t c, input logic extra_strobe);
    logic exp_stop;
    logic got_stop;
    int   n;
    exp_stop = model_cmd(c);
    for (n = 0; n < 2000 && cmd_busy; n++) @(negedge clk);
    if (cmd_busy) begin
      $display("timeout: cmd_busy never went low before a new command");
      errors++;
    end
    cmd       = c;
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    check_val("cmd_busy after accept", 64'(cmd_busy), 64'd1);
    if (extra_strobe) begin  // must be dropped while busy
      cmd       = make_cmd(OP_LINE, 5, 5, 300, 200, 0);
      cmd_valid = 1'b1;
      @(negedge clk);
      cmd_valid = 1'b0;
    end
    got_stop = 1'b0;
    for (n = 0; n < 2000 && !cmd_done; n++) @(negedge clk);
    if (!cmd_done) begin
      $display("timeout: no cmd_done within 2000 cycles");
      errors++;
    end else begin
      got_stop = cmd_stopped;
      check_val("cmd_busy with cmd_done", 64'(cmd_busy), 64'd0);
    end
    for (n = 0; n < 2000 && (exp_q.size() != 0 || wr_en); n++) @(negedge clk);
    check_val("cmd_stopped", 64'(got_stop), 64'(exp_stop));
    if (exp_q.size() != 0 || wr_en) begin
      $display("timeout: writes still pending 2000 cycles after cmd_done, %0d expected left",
               exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
      tests_pass++;
    end else begin
      $display("test %s: %0d errors", name, errors - err_before);
      tests_fail++;
    end
  endtask

  task automatic random_line(input int lo_x, input int hi_x, input int lo_y, input int hi_y);
    run_cmd(make_cmd(OP_LINE, rand_range(lo_x, hi_x), rand_range(lo_y, hi_y),
                     rand_range(lo_x, hi_x), rand_range(lo_y, hi_y), 0), 1'b0);
  endtask

  initial begin
    int e0;
    int i;
    int ay;
    int by;
    int oct_dx[8];
    int oct_dy[8];
    seed       = 32'h2a82_a7e4;
    clk        = 1'b0;
    arst_n     = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    mem_stall  = 1'b0;
    stall_on   = 1'b0;
    held       = 1'b0;
    errors     = 0;
    tests_pass = 0;
    tests_fail = 0;
    oct_dx     = '{100, 40, -40, -100, -100, -40, 40, 100};  // one end point per octant
    oct_dy     = '{40, 100, 100, 40, -40, -100, -100, -40};
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    e0 = errors;
    for (i = 0; i < 20; i++) begin
      run_cmd(make_cmd(OP_POINT, rand_range(0, 639), rand_range(0, 479),
                       rand_range(0, 639), rand_range(0, 479), 0), 1'b0);
    end
    end_test("points", e0);

    e0 = errors;
    run_cmd(make_cmd(OP_LINE, 10, 50, 200, 50, 0), 1'b0);    // horizontal
    run_cmd(make_cmd(OP_LINE, 300, 400, 300, 20, 0), 1'b0);  // vertical upward
    run_cmd(make_cmd(OP_LINE, 77, 88, 77, 88, 0), 1'b0);     // a equal to b
    for (i = 0; i < 8; i++) begin  // out from the centre into each octant
      run_cmd(make_cmd(OP_LINE, 320, 240, 320 + oct_dx[i], 240 + oct_dy[i], 0), 1'b0);
    end
    for (i = 0; i < 40; i++) random_line(0, 639, 0, 479);
    end_test("lines", e0);

    e0 = errors;
    for (i = 0; i < 20; i++) begin
      ay = rand_range(0, 479);
      by = rand_range(0, 479);
      if (by < ay + 2 && by > ay - 2) by = (ay < 240) ? ay + 50 : ay - 50;
      run_cmd(make_cmd(OP_LINE_TO_Y, rand_range(0, 639), ay, rand_range(0, 639), by,
                       (ay < by) ? rand_range(ay + 1, by - 1) : rand_range(by + 1, ay - 1)),
              1'b0);
    end
    end_test("stop on scanline", e0);

    e0 = errors;
    for (i = 0; i < 25; i++) random_line(-200, 840, -200, 680);
    end_test("clipping", e0);

    e0 = errors;
    stall_on = 1'b1;
    for (i = 0; i < 30; i++) random_line(-50, 690, -50, 530);
    stall_on = 1'b0;
    end_test("memory stall", e0);

    e0 = errors;
    for (i = 0; i < 10; i++) begin
      run_cmd(make_cmd(OP_LINE, rand_range(0, 639), rand_range(0, 479),
                       rand_range(0, 639), rand_range(0, 479), 0), 1'b1);
    end
    run_cmd(make_cmd(OP_POINT, 1, 2, 3, 4, 0), 1'b1);
    end_test("strobe while busy", e0);

    $display("tests passed %0d, tests failed %0d, errors %0d", tests_pass, tests_fail, errors);
    if (errors == 0 && tests_fail == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
design/gfx_pkg.sv
design/line_generator.sv
design/geo_cmd_seq.sv
design/pixel_writer.sv
design/geo_draw_top.sv
dv/tb_line_model.sv
dv/tb_geo_draw.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the geo_draw testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_geo_draw \
  -f flist.f \
  -o sim_geo_draw

./obj_dir/sim_geo_draw | tee sim.log

if grep -q "^\*\* PASS \*\*$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
